/* all.f */
+incdir+source
source/cache_pkg.sv
source/limp_if.sv
source/lutram.sv
source/line_store.sv
source/load_aligner.sv
source/cache_ctrl.sv
source/cache_top.sv
tb/cache_assertions.sv
tb/cache_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the cache testbench with Verilator, runs it and checks the log
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module cache_tb \
    --Mdir obj_dir -o cache_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/cache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "=== PASS ===" sim.log; then
    exit 0
else
    echo "pass line not found in sim.log"
    exit 1
fi

/* source/cache_ctrl.sv */
// one request at a time; OFFSET_WIDTH must be at least 1 and writes never allocate a line
`include "cache_defines.svh"

module cache_ctrl #(
    parameter int INDEX_WIDTH  = `DEF_INDEX_WIDTH,
    parameter int OFFSET_WIDTH = `DEF_OFFSET_WIDTH,
    localparam int TAG_WIDTH   = `PADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH - 2,
    localparam int LINE_WORDS  = 2 ** OFFSET_WIDTH
) (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    limp_if.servicer                stage_limp,
    limp_if.requestor               mem_limp,
    input  logic [TAG_WIDTH-1:0]    i_rtag,
    input  logic                    i_rvalid,
    input  cache_pkg::word_t        i_aligned_rdata,
    output logic [INDEX_WIDTH-1:0]  o_index,
    output logic [OFFSET_WIDTH-1:0] o_word_offset,
    output logic [1:0]              o_byte_offset,
    output logic                    o_line_wen,
    output logic [LINE_WORDS-1:0]   o_word_wen,
    output logic                    o_tag_wen,
    output logic [TAG_WIDTH-1:0]    o_wtag,
    output logic                    o_set_valid,
    output logic                    o_invalidate
);
    import cache_pkg::*;

    cache_state_e          state;
    cache_state_e          state_next;
    logic [TAG_WIDTH-1:0]  stage_tag;
    paddr_t                refill_addr;
    logic [LINE_WORDS-1:0] word_wen;
    logic                  passthrough;
    logic                  line_hit;
    logic                  read_hit;
    logic                  fill_beat;

    // the address splits into tag, line index, word offset and byte offset
    always_comb begin
        stage_tag     = stage_limp.addr[`PADDR_WIDTH-1 -: TAG_WIDTH];
        o_index       = stage_limp.addr[OFFSET_WIDTH + 2 +: INDEX_WIDTH];
        o_word_offset = stage_limp.addr[2 +: OFFSET_WIDTH];
        o_byte_offset = stage_limp.addr[1:0];
    end

    // writes and uncacheable reads bypass the line store entirely
    assign passthrough = stage_limp.wen_nren || stage_limp.uncacheable;
    // the indexed line holds this address, whatever kind of request it is
    assign line_hit    = i_rvalid && (i_rtag == stage_tag);
    assign read_hit    = stage_limp.valid && !passthrough && line_hit;
    // one refill word is taken from memory
    assign fill_beat   = (state == CACHE_STATE_FILL) && mem_limp.ready;

    // state, refill address counter and the one-hot word enable shifter
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state       <= CACHE_STATE_IDLE;
            refill_addr <= '0;
            word_wen    <= '0;
        end else begin
            state <= state_next;
            if (state == CACHE_STATE_IDLE) begin
                // preload with the line base and the first word slot
                refill_addr <= {stage_tag, o_index, {(OFFSET_WIDTH + 2){1'b0}}};
                word_wen    <= LINE_WORDS'(1);
            end else if (fill_beat) begin
                // both hold while memory stalls
                refill_addr <= refill_addr + paddr_t'(4);
                word_wen    <= word_wen << 1;
            end
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            CACHE_STATE_IDLE: begin
                // only a cacheable read that misses starts a refill
                if (stage_limp.valid && !passthrough && !line_hit) begin
                    state_next = CACHE_STATE_FILL;
                end
            end
            CACHE_STATE_FILL: begin
                // done once the last word slot has been written
                if (fill_beat && word_wen[LINE_WORDS-1]) begin
                    state_next = CACHE_STATE_WRITE_TAG;
                end
            end
            CACHE_STATE_WRITE_TAG: begin
                // the tag lands this cycle and the request hits on the next one
                state_next = CACHE_STATE_IDLE;
            end
            default: begin
                state_next = CACHE_STATE_IDLE;
            end
        endcase
    end

    // line store controls, the refill always targets the index of the waiting request
    always_comb begin
        o_line_wen  = fill_beat;
        o_word_wen  = word_wen;
        o_tag_wen   = state == CACHE_STATE_WRITE_TAG;
        o_set_valid = state == CACHE_STATE_WRITE_TAG;
        o_wtag      = stage_tag;
        // drop the line when a store to an address it holds goes out
        o_invalidate = stage_limp.valid && stage_limp.wen_nren && mem_limp.ready && line_hit;
    end

    // steer either the stage request or the refill onto the memory port
    always_comb begin
        if (passthrough) begin
            mem_limp.valid       = stage_limp.valid;
            mem_limp.wen_nren    = stage_limp.wen_nren;
            mem_limp.size        = stage_limp.size;
            mem_limp.addr        = stage_limp.addr;
            mem_limp.wdata       = stage_limp.wdata;
            mem_limp.uncacheable = stage_limp.uncacheable;
            stage_limp.ready     = mem_limp.ready;
            stage_limp.rdata     = mem_limp.rdata;
        end else begin
            // refills are whole-word cacheable reads
            mem_limp.valid       = state == CACHE_STATE_FILL;
            mem_limp.wen_nren    = 1'b0;
            mem_limp.size        = SIZE_WORD;
            mem_limp.addr        = refill_addr;
            mem_limp.wdata       = '0;
            mem_limp.uncacheable = 1'b0;
            stage_limp.ready     = read_hit;
            stage_limp.rdata     = i_aligned_rdata;
        end
    end

endmodule

/* source/cache_defines.svh */
// global widths for the cache; the address is byte-addressed and a word is fixed at 32 bits
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// physical address width in bits
`define PADDR_WIDTH 32
// data word width in bits, the byte and halfword extraction assumes 32
`define WORD_WIDTH 32
// 16 lines of 4 words unless a parameter overrides these
`define DEF_INDEX_WIDTH 4
`define DEF_OFFSET_WIDTH 2

`endif

/* source/cache_pkg.sv */
// shared types for the cache; the size and state encodings are 2 bits wide and must not grow
`include "cache_defines.svh"

package cache_pkg;

    typedef logic [`WORD_WIDTH-1:0] word_t;
    typedef logic [`PADDR_WIDTH-1:0] paddr_t;

    // access size of a stage or memory request
    typedef enum logic [1:0] {
        SIZE_BYTE     = 2'd0,
        SIZE_HALFWORD = 2'd1,
        SIZE_WORD     = 2'd2
    } size_e;

    // refill controller states
    typedef enum logic [1:0] {
        CACHE_STATE_IDLE      = 2'd0,
        CACHE_STATE_FILL      = 2'd1,
        CACHE_STATE_WRITE_TAG = 2'd2
    } cache_state_e;

endpackage

/* source/cache_top.sv */
// cache top with plain stage and memory ports; memory must answer refill reads as whole words
`include "cache_defines.svh"

module cache_top #(
    parameter int INDEX_WIDTH  = `DEF_INDEX_WIDTH,
    parameter int OFFSET_WIDTH = `DEF_OFFSET_WIDTH
) (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_flush,
    input  logic             i_stage_valid,
    input  logic             i_stage_wen_nren,
    input  cache_pkg::size_e i_stage_size,
    input  cache_pkg::paddr_t i_stage_addr,
    input  cache_pkg::word_t i_stage_wdata,
    input  logic             i_stage_uncacheable,
    output logic             o_stage_ready,
    output cache_pkg::word_t o_stage_rdata,
    output logic             o_mem_valid,
    output logic             o_mem_wen_nren,
    output cache_pkg::size_e o_mem_size,
    output cache_pkg::paddr_t o_mem_addr,
    output cache_pkg::word_t o_mem_wdata,
    output logic             o_mem_uncacheable,
    input  logic             i_mem_ready,
    input  cache_pkg::word_t i_mem_rdata
);
    import cache_pkg::*;

    localparam int TAG_WIDTH  = `PADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH - 2;
    localparam int LINE_WORDS = 2 ** OFFSET_WIDTH;

    logic [INDEX_WIDTH-1:0]  index;
    logic [OFFSET_WIDTH-1:0] word_offset;
    logic [1:0]              byte_offset;
    logic                    line_wen;
    logic [LINE_WORDS-1:0]   word_wen;
    logic                    tag_wen;
    logic [TAG_WIDTH-1:0]    wtag;
    logic                    set_valid;
    logic                    invalidate;
    word_t [LINE_WORDS-1:0]  rline;
    logic [TAG_WIDTH-1:0]    rtag;
    logic                    rvalid;
    word_t                   aligned_rdata;

    limp_if stage_limp ();
    limp_if mem_limp ();

    // the stage pins act as requestor on stage_limp
    assign stage_limp.valid       = i_stage_valid;
    assign stage_limp.wen_nren    = i_stage_wen_nren;
    assign stage_limp.size        = i_stage_size;
    assign stage_limp.addr        = i_stage_addr;
    assign stage_limp.wdata       = i_stage_wdata;
    assign stage_limp.uncacheable = i_stage_uncacheable;
    assign o_stage_ready          = stage_limp.ready;
    assign o_stage_rdata          = stage_limp.rdata;

    // the memory pins face the external servicer of mem_limp
    assign o_mem_valid       = mem_limp.valid;
    assign o_mem_wen_nren    = mem_limp.wen_nren;
    assign o_mem_size        = mem_limp.size;
    assign o_mem_addr        = mem_limp.addr;
    assign o_mem_wdata       = mem_limp.wdata;
    assign o_mem_uncacheable = mem_limp.uncacheable;
    assign mem_limp.ready    = i_mem_ready;
    assign mem_limp.rdata    = i_mem_rdata;

    cache_ctrl #(
        .INDEX_WIDTH (INDEX_WIDTH),
        .OFFSET_WIDTH(OFFSET_WIDTH)
    ) ctrl0 (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .stage_limp     (stage_limp.servicer),
        .mem_limp       (mem_limp.requestor),
        .i_rtag         (rtag),
        .i_rvalid       (rvalid),
        .i_aligned_rdata(aligned_rdata),
        .o_index        (index),
        .o_word_offset  (word_offset),
        .o_byte_offset  (byte_offset),
        .o_line_wen     (line_wen),
        .o_word_wen     (word_wen),
        .o_tag_wen      (tag_wen),
        .o_wtag         (wtag),
        .o_set_valid    (set_valid),
        .o_invalidate   (invalidate)
    );

    // reads and refill writes share one index since the store is only filled on a miss
    line_store #(
        .INDEX_WIDTH (INDEX_WIDTH),
        .OFFSET_WIDTH(OFFSET_WIDTH)
    ) store0 (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_flush     (i_flush),
        .i_rindex    (index),
        .i_windex    (index),
        .i_line_wen  (line_wen),
        .i_word_wen  (word_wen),
        .i_wword     (i_mem_rdata),
        .i_tag_wen   (tag_wen),
        .i_wtag      (wtag),
        .i_set_valid (set_valid),
        .i_invalidate(invalidate),
        .o_rline     (rline),
        .o_rtag      (rtag),
        .o_rvalid    (rvalid)
    );

    load_aligner #(
        .OFFSET_WIDTH(OFFSET_WIDTH)
    ) aligner0 (
        .i_line       (rline),
        .i_word_offset(word_offset),
        .i_byte_offset(byte_offset),
        .i_size       (i_stage_size),
        .o_rdata      (aligned_rdata)
    );

endmodule

/* source/limp_if.sv */
// valid/ready request link; the requestor holds every request field stable until ready
interface limp_if;
    import cache_pkg::*;

    // request side, driven by the requestor
    logic   valid;
    logic   wen_nren;
    size_e  size;
    paddr_t addr;
    word_t  wdata;
    logic   uncacheable;

    // response side, driven by the servicer
    // rdata only means something in the cycle where valid and ready are both high
    logic   ready;
    word_t  rdata;

    modport requestor (
        output valid,
        output wen_nren,
        output size,
        output addr,
        output wdata,
        output uncacheable,
        input  ready,
        input  rdata
    );

    modport servicer (
        input  valid,
        input  wen_nren,
        input  size,
        input  addr,
        input  wdata,
        input  uncacheable,
        output ready,
        output rdata
    );

endinterface

/* source/line_store.sv */
// line data and tags live in RAM, valid bits in flops; flush wins over set-valid in the same cycle
`include "cache_defines.svh"

module line_store #(
    parameter int INDEX_WIDTH  = `DEF_INDEX_WIDTH,
    parameter int OFFSET_WIDTH = `DEF_OFFSET_WIDTH,
    localparam int TAG_WIDTH   = `PADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH - 2,
    localparam int LINE_WORDS  = 2 ** OFFSET_WIDTH,
    localparam int DEPTH       = 2 ** INDEX_WIDTH
) (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  logic                                i_flush,
    input  logic [INDEX_WIDTH-1:0]              i_rindex,
    input  logic [INDEX_WIDTH-1:0]              i_windex,
    input  logic                                i_line_wen,
    input  logic [LINE_WORDS-1:0]               i_word_wen,
    input  cache_pkg::word_t                    i_wword,
    input  logic                                i_tag_wen,
    input  logic [TAG_WIDTH-1:0]                i_wtag,
    input  logic                                i_set_valid,
    input  logic                                i_invalidate,
    output cache_pkg::word_t [LINE_WORDS-1:0]   o_rline,
    output logic [TAG_WIDTH-1:0]                o_rtag,
    output logic                                o_rvalid
);

    logic [DEPTH-1:0] line_valid;

    // the refill word goes to every lane and the one-hot word enable picks its slot
    lutram #(
        .DEPTH (DEPTH),
        .DWIDTH(LINE_WORDS * `WORD_WIDTH),
        .BWIDTH(`WORD_WIDTH)
    ) data_ram (
        .i_clk  (i_clk),
        .i_wen  (i_line_wen),
        .i_waddr(i_windex),
        .i_wben (i_word_wen),
        .i_wdata({LINE_WORDS{i_wword}}),
        .i_raddr(i_rindex),
        .o_rdata(o_rline)
    );

    // a tag is always written whole, so it is one lane wide
    lutram #(
        .DEPTH (DEPTH),
        .DWIDTH(TAG_WIDTH),
        .BWIDTH(TAG_WIDTH)
    ) tag_ram (
        .i_clk  (i_clk),
        .i_wen  (i_tag_wen),
        .i_waddr(i_windex),
        .i_wben (1'b1),
        .i_wdata(i_wtag),
        .i_raddr(i_rindex),
        .o_rdata(o_rtag)
    );

    // keeping valid bits in flops lets a flush clear every line in one cycle
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            line_valid <= '0;
        end else if (i_flush) begin
            line_valid <= '0;
        end else if (i_set_valid) begin
            line_valid[i_windex] <= 1'b1;
        end else if (i_invalidate) begin
            // a write-through store makes the cached copy stale
            line_valid[i_windex] <= 1'b0;
        end
    end

    assign o_rvalid = line_valid[i_rindex];

endmodule

/* source/load_aligner.sv */
// zero-extends byte and halfword loads; a halfword at byte offset 1 or 3 is treated as offset 0 or 2
module load_aligner #(
    parameter int OFFSET_WIDTH = 2,
    localparam int LINE_WORDS  = 2 ** OFFSET_WIDTH
) (
    input  cache_pkg::word_t [LINE_WORDS-1:0]   i_line,
    input  logic [OFFSET_WIDTH-1:0]             i_word_offset,
    input  logic [1:0]                          i_byte_offset,
    input  cache_pkg::size_e                    i_size,
    output cache_pkg::word_t                    o_rdata
);
    import cache_pkg::*;

    word_t word;

    always_comb begin
        // first pick the word that the address points at inside the line
        word = i_line[i_word_offset];

        case (i_size)
            SIZE_BYTE: begin
                o_rdata = word_t'(word[8*i_byte_offset +: 8]);
            end
            SIZE_HALFWORD: begin
                // the upper halfword when bit 1 of the byte offset is set
                o_rdata = word_t'(word[16*i_byte_offset[1] +: 16]);
            end
            default: begin
                o_rdata = word;
            end
        endcase
    end

endmodule

/* source/lutram.sv */
// distributed RAM with async read and lane write enables; DWIDTH must be a multiple of BWIDTH
module lutram #(
    parameter int DEPTH  = 16,
    parameter int DWIDTH = 32,
    parameter int BWIDTH = 8,
    localparam int LANES  = DWIDTH / BWIDTH,
    localparam int AWIDTH = $clog2(DEPTH)
) (
    input  logic              i_clk,
    input  logic              i_wen,
    input  logic [AWIDTH-1:0] i_waddr,
    input  logic [LANES-1:0]  i_wben,
    input  logic [DWIDTH-1:0] i_wdata,
    input  logic [AWIDTH-1:0] i_raddr,
    output logic [DWIDTH-1:0] o_rdata
);

    // contents come up undefined, callers track validity on their own
    logic [DWIDTH-1:0] mem [DEPTH];

    // only the lanes with their enable set are updated
    always_ff @(posedge i_clk) begin
        if (i_wen) begin
            for (int i = 0; i < LANES; i++) begin
                if (i_wben[i]) begin
                    mem[i_waddr][i*BWIDTH +: BWIDTH] <= i_wdata[i*BWIDTH +: BWIDTH];
                end
            end
        end
    end

    // read is combinational so a hit can be answered in the request cycle
    assign o_rdata = mem[i_raddr];

endmodule

/* tb/cache_assertions.sv */
// protocol checks for cache_ctrl; bound from the testbench and assumes no flush while a refill runs
module cache_assertions (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  cache_pkg::cache_state_e i_state,
    input  logic                    i_stage_valid,
    input  logic                    i_stage_ready,
    input  logic                    i_stage_wen_nren,
    input  logic                    i_stage_uncacheable,
    input  cache_pkg::size_e        i_stage_size,
    input  cache_pkg::paddr_t       i_stage_addr,
    input  cache_pkg::word_t        i_stage_wdata,
    input  logic                    i_mem_valid
);
    import cache_pkg::*;

    // a cacheable read in IDLE is either a hit or about to start a refill, never a memory access
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_state == CACHE_STATE_IDLE && i_stage_valid && !i_stage_wen_nren
            && !i_stage_uncacheable) |-> !i_mem_valid)
        else $error("memory valid raised in IDLE for a cacheable request");

    // the tag write is a single cycle, and the waiting request hits right after it
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_state == CACHE_STATE_WRITE_TAG) |=> (i_state == CACHE_STATE_IDLE && i_stage_ready))
        else $error("WRITE_TAG not followed by a hit in IDLE");

    // a waiting request keeps valid and all of its fields until ready
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_stage_valid && !i_stage_ready) |=> (i_stage_valid && $stable(i_stage_addr)
            && $stable(i_stage_size) && $stable(i_stage_wen_nren) && $stable(i_stage_wdata)
            && $stable(i_stage_uncacheable)))
        else $error("stage request changed while waiting for ready");

endmodule

/* tb/cache_tb.sv */
// drives cache_top through hits, misses, writes, uncacheable reads and flush; memory is modeled here
`include "cache_defines.svh"

module cache_tb;
    import cache_pkg::*;

    localparam int LINE_WORDS = 2 ** `DEF_OFFSET_WIDTH;
    localparam int TIMEOUT    = 200;

    logic   i_clk;
    logic   i_rst_n;
    logic   i_flush;
    logic   i_stage_valid;
    logic   i_stage_wen_nren;
    size_e  i_stage_size;
    paddr_t i_stage_addr;
    word_t  i_stage_wdata;
    logic   i_stage_uncacheable;
    logic   o_stage_ready;
    word_t  o_stage_rdata;
    logic   o_mem_valid;
    logic   o_mem_wen_nren;
    size_e  o_mem_size;
    paddr_t o_mem_addr;
    word_t  o_mem_wdata;
    logic   o_mem_uncacheable;
    logic   i_mem_ready;
    word_t  i_mem_rdata;

    // sparse memory behind the port and the shadow copy that the stage side expects
    word_t  mem_words [paddr_t];
    word_t  shadow_words [paddr_t];
    paddr_t read_log [$];
    paddr_t last_mem_addr;
    size_e  last_mem_size;
    word_t  last_mem_wdata;
    logic   last_mem_wen;
    logic   last_mem_unc;
    int     wait_cycles;
    int     reads_issued;
    int     reads_checked;

    cache_top dut0 (.*);

    bind cache_ctrl cache_assertions asrt0 (
        .i_clk              (i_clk),
        .i_rst_n            (i_rst_n),
        .i_state            (state),
        .i_stage_valid      (stage_limp.valid),
        .i_stage_ready      (stage_limp.ready),
        .i_stage_wen_nren   (stage_limp.wen_nren),
        .i_stage_uncacheable(stage_limp.uncacheable),
        .i_stage_size       (stage_limp.size),
        .i_stage_addr       (stage_limp.addr),
        .i_stage_wdata      (stage_limp.wdata),
        .i_mem_valid        (mem_limp.valid)
    );

    always #50 i_clk = ~i_clk;

    // untouched words take a value that mixes every address bit
    function automatic word_t fill_word(paddr_t waddr);
        return (waddr * 32'h9e37_79b9) ^ 32'hc3a5_5a3c;
    endfunction

    function automatic word_t mem_word(paddr_t waddr);
        return mem_words.exists(waddr) ? mem_words[waddr] : fill_word(waddr);
    endfunction

    function automatic word_t shadow_word(paddr_t waddr);
        return shadow_words.exists(waddr) ? shadow_words[waddr] : fill_word(waddr);
    endfunction

    // a halfword is picked by bit 1 of the byte offset, and narrow reads are zero-extended
    function automatic word_t extract(word_t w, logic [1:0] boff, size_e size);
        case (size)
            SIZE_BYTE:     return (w >> {boff, 3'b000}) & 32'h0000_00ff;
            SIZE_HALFWORD: return (w >> {boff[1], 4'b0000}) & 32'h0000_ffff;
            default:       return w;
        endcase
    endfunction

    // store data sits in the low bits and lands on the addressed lanes
    function automatic word_t merge(word_t old, logic [1:0] boff, size_e size, word_t data);
        word_t mask;
        word_t placed;
        case (size)
            SIZE_BYTE: begin
                mask   = 32'h0000_00ff << {boff, 3'b000};
                placed = data << {boff, 3'b000};
            end
            SIZE_HALFWORD: begin
                mask   = 32'h0000_ffff << {boff[1], 4'b0000};
                placed = data << {boff[1], 4'b0000};
            end
            default: begin
                mask   = 32'hffff_ffff;
                placed = data;
            end
        endcase
        return (old & ~mask) | (placed & mask);
    endfunction

    // reference for a stage read, taken from the shadow copy
    function automatic word_t expected_read(paddr_t addr, size_e size);
        return extract(shadow_word({addr[31:2], 2'b00}), addr[1:0], size);
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: %s = 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    // memory answers with random stalls and sized read data
    always begin
        @(posedge i_clk);
        #2;
        i_mem_ready = ($urandom % 4) != 0;
        i_mem_rdata = extract(mem_word({o_mem_addr[31:2], 2'b00}), o_mem_addr[1:0], o_mem_size);
        @(negedge i_clk);
        if (i_rst_n && o_mem_valid && i_mem_ready) begin
            last_mem_addr  = o_mem_addr;
            last_mem_size  = o_mem_size;
            last_mem_wdata = o_mem_wdata;
            last_mem_wen   = o_mem_wen_nren;
            last_mem_unc   = o_mem_uncacheable;
            if (o_mem_wen_nren) begin
                mem_words[{o_mem_addr[31:2], 2'b00}] = merge(mem_word({o_mem_addr[31:2], 2'b00}),
                    o_mem_addr[1:0], o_mem_size, o_mem_wdata);
            end else begin
                read_log.push_back(o_mem_addr);
            end
        end
    end

    // every accepted stage read is compared, accepted writes update the shadow copy
    always @(negedge i_clk) begin
        if (i_rst_n && i_stage_valid && o_stage_ready) begin
            if (i_stage_wen_nren) begin
                shadow_words[{i_stage_addr[31:2], 2'b00}] = merge(
                    shadow_word({i_stage_addr[31:2], 2'b00}), i_stage_addr[1:0],
                    i_stage_size, i_stage_wdata);
            end else begin
                check("o_stage_rdata", o_stage_rdata, expected_read(i_stage_addr, i_stage_size));
                reads_checked++;
            end
        end
    end

    // one stage request, held until ready; the log of memory reads restarts with it
    task automatic stage_request(input logic wen, input size_e size, input paddr_t addr,
                                 input word_t wdata, input logic unc);
        int cycles;
        cycles = 0;
        @(posedge i_clk);
        #1;
        read_log.delete();
        i_stage_valid       = 1'b1;
        i_stage_wen_nren    = wen;
        i_stage_size        = size;
        i_stage_addr        = addr;
        i_stage_wdata       = wdata;
        i_stage_uncacheable = unc;
        if (!wen) begin
            reads_issued++;
        end
        @(negedge i_clk);
        while (!o_stage_ready) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                fail_run($sformatf("no stage ready within %0d cycles for address %08h",
                    TIMEOUT, addr));
            end
            @(negedge i_clk);
        end
        wait_cycles = cycles;
        @(posedge i_clk);
        #1;
        i_stage_valid = 1'b0;
    endtask

    // a refill reads every word of the line in order from the line base
    task automatic check_refill(input paddr_t addr);
        paddr_t base;
        base = addr & ~paddr_t'(LINE_WORDS * 4 - 1);
        check("refill read count", 32'(read_log.size()), LINE_WORDS);
        foreach (read_log[i]) begin
            check("o_mem_addr", read_log[i], base + paddr_t'(4 * i));
        end
    endtask

    task automatic check_hit();
        check("hit read count", 32'(read_log.size()), 0);
        check("hit wait cycles", 32'(wait_cycles), 0);
    endtask

    initial begin
        void'($urandom(32'h60bf_ba84));
        i_clk               = 1'b0;
        i_rst_n             = 1'b0;
        i_flush             = 1'b0;
        i_stage_valid       = 1'b0;
        i_stage_wen_nren    = 1'b0;
        i_stage_size        = SIZE_WORD;
        i_stage_addr        = '0;
        i_stage_wdata       = '0;
        i_stage_uncacheable = 1'b0;
        i_mem_ready         = 1'b0;
        i_mem_rdata         = '0;
        reads_issued        = 0;
        reads_checked       = 0;
        repeat (8) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;
        @(negedge i_clk);
        check("o_mem_valid", 32'(o_mem_valid), 0);
        check("o_stage_ready", 32'(o_stage_ready), 0);

        // cold miss, then hits on the same line at every size and offset
        stage_request(1'b0, SIZE_WORD, 32'h0000_1048, '0, 1'b0);
        check_refill(32'h0000_1048);
        stage_request(1'b0, SIZE_WORD, 32'h0000_1048, '0, 1'b0);
        check_hit();
        for (int b = 0; b < 4; b++) begin
            stage_request(1'b0, SIZE_BYTE, 32'h0000_104c + paddr_t'(b), '0, 1'b0);
            check_hit();
            stage_request(1'b0, SIZE_HALFWORD, 32'h0000_1040 + paddr_t'(b), '0, 1'b0);
            check_hit();
        end

        // stores go straight to memory and drop the cached line
        stage_request(1'b1, SIZE_WORD, 32'h0000_1044, 32'hdead_beef, 1'b0);
        check("o_mem_wen_nren", 32'(last_mem_wen), 1);
        check("o_mem_addr", last_mem_addr, 32'h0000_1044);
        check("o_mem_size", 32'(last_mem_size), 32'(SIZE_WORD));
        check("o_mem_wdata", last_mem_wdata, 32'hdead_beef);
        stage_request(1'b1, SIZE_BYTE, 32'h0000_104a, 32'h0000_005a, 1'b0);
        check("o_mem_addr", last_mem_addr, 32'h0000_104a);
        check("o_mem_size", 32'(last_mem_size), 32'(SIZE_BYTE));
        check("o_mem_wdata", last_mem_wdata, 32'h0000_005a);
        stage_request(1'b0, SIZE_WORD, 32'h0000_1044, '0, 1'b0);
        check_refill(32'h0000_1044);
        stage_request(1'b0, SIZE_WORD, 32'h0000_1048, '0, 1'b0);
        check_hit();

        // uncacheable reads always go out as a single access
        for (int n = 0; n < 2; n++) begin
            stage_request(1'b0, SIZE_HALFWORD, 32'h0000_2106, '0, 1'b1);
            check("uncacheable read count", 32'(read_log.size()), 1);
            check("o_mem_addr", last_mem_addr, 32'h0000_2106);
            check("o_mem_size", 32'(last_mem_size), 32'(SIZE_HALFWORD));
            check("o_mem_uncacheable", 32'(last_mem_unc), 1);
        end
        stage_request(1'b0, SIZE_WORD, 32'h0000_2104, '0, 1'b0);
        check_refill(32'h0000_2104);

        // flush forgets a cached line
        stage_request(1'b0, SIZE_WORD, 32'h0000_3004, '0, 1'b0);
        check_refill(32'h0000_3004);
        @(posedge i_clk);
        #1;
        i_flush = 1'b1;
        @(posedge i_clk);
        #1;
        i_flush = 1'b0;
        stage_request(1'b0, SIZE_WORD, 32'h0000_3004, '0, 1'b0);
        check_refill(32'h0000_3004);

        // same index with another tag evicts in both directions
        stage_request(1'b0, SIZE_WORD, 32'h0000_3108, '0, 1'b0);
        check_refill(32'h0000_3108);
        stage_request(1'b0, SIZE_WORD, 32'h0000_3000, '0, 1'b0);
        check_refill(32'h0000_3000);
        stage_request(1'b0, SIZE_BYTE, 32'h0000_3003, '0, 1'b0);
        check_hit();

        check("reads_checked", 32'(reads_checked), 32'(reads_issued));
        $display("=== PASS ===");
        $finish;
    end

endmodule
